// ==== Bender.yml ====
package:
  name: wr_path

# packages first, then the RTL in dependency order
sources:
  - files:
      - hw/phy_data_pkg.sv
      - hw/phy_ctrl_pkg.sv
      - hw/ddio_out_soft.sv
      - hw/wr_burst_ctrl.sv
      - hw/wr_path_top.sv

  # testbench with its model header
  - target: test
    include_dirs:
      - tests
    files:
      - tests/wr_path_tb.sv

// ==== hw/ddio_out_soft.sv ====
/*
 * soft logic DDIO output block
 * registers a two-item word on clk and muxes the items by clk phase
 */

module ddio_out_soft #(
	// width of one item, i.e. of the pins driven
	parameter int ITEM_WIDTH = 1,
	// level of the input register after reset
	parameter bit REG_POST_RESET_HIGH = 1'b0
) (
	input  logic                    clk,
	input  logic                    dr_reset_n,
	// item 0 in the low half, item 1 in the high half
	input  logic [2*ITEM_WIDTH-1:0] datain,
	output logic [ITEM_WIDTH-1:0]   dataout
);

	// ************************************************************************
	// input register
	// ************************************************************************

	// full word captured on the rising edge
	logic [2*ITEM_WIDTH-1:0] datain_r;

	// the two items split out of the registered word
	logic [ITEM_WIDTH-1:0] item_hi_phase;
	logic [ITEM_WIDTH-1:0] item_lo_phase;

	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			// all ones or all zeros, picked per instance
			datain_r <= {(2 * ITEM_WIDTH){REG_POST_RESET_HIGH}};
		end else begin
			datain_r <= datain;
		end
	end

	// ************************************************************************
	// rate doubling mux
	// ************************************************************************

	// item 0 belongs to the first half of the cycle
	assign item_hi_phase = datain_r[ITEM_WIDTH-1:0];

	// item 1 to the second half
	assign item_lo_phase = datain_r[2*ITEM_WIDTH-1:ITEM_WIDTH];

	// clk itself is the select
	// high phase right after the capturing edge drives item 0,
	// low phase drives item 1, so both items leave in one cycle
	// the register is stable for the whole cycle, only the select moves
	always_comb begin
		if (clk) begin
			dataout = item_hi_phase;
		end else begin
			dataout = item_lo_phase;
		end
	end

	// after reset the register holds the same level in both items,
	// so the pin is steady in both phases until the first real word

endmodule

// ==== hw/phy_ctrl_pkg.sv ====
/*
 * control side constants of the DDR write path
 * pipeline depth, DQS beat patterns, post-reset level of dqs_n
 */

package phy_ctrl_pkg;

	// register stages from wr_en to the DDIO inputs
	// stage WR_PIPE_DEPTH-2 vs stage WR_PIPE_DEPTH-1 gives the preamble
	localparam int WR_PIPE_DEPTH = 2;

	// ************************************************************************
	// strobe words, item 0 goes out in the high clk phase
	// ************************************************************************

	// data cycle: dqs high while clk is high, low while clk is low
	localparam logic [phy_data_pkg::BEATS_PER_CYCLE-1:0] DQS_DATA_PATTERN = 2'b01;

	// preamble and idle: dqs held low for the whole cycle
	localparam logic [phy_data_pkg::BEATS_PER_CYCLE-1:0] DQS_PREAMBLE_PATTERN = 2'b00;

	// ************************************************************************
	// reset levels
	// ************************************************************************

	// complementary strobe comes out of reset high so dqs/dqs_n stay
	// a valid differential pair, all other DDIO blocks reset low
	localparam bit DQS_N_RESET_HIGH = 1'b1;

endpackage

// ==== hw/phy_data_pkg.sv ====
/*
 * data side widths of the DDR write path
 * DQ and DM pins per beat, beats per clk cycle, controller word widths
 */

package phy_data_pkg;

	// ************************************************************************
	// pin widths per DDR beat
	// ************************************************************************

	// data pins driven on each beat
	localparam int DQ_WIDTH = 16;

	// one mask pin per byte lane
	localparam int DM_WIDTH = 2;

	// two beats leave the PHY per clk cycle, one per clk phase
	localparam int BEATS_PER_CYCLE = 2;

	// ************************************************************************
	// controller side words
	// ************************************************************************

	// beat 0 sits in the low half, beat 1 in the high half
	localparam int WDATA_WIDTH = DQ_WIDTH * BEATS_PER_CYCLE;

	// mask word laid out the same way as the data word
	localparam int WDM_WIDTH = DM_WIDTH * BEATS_PER_CYCLE;

endpackage

// ==== hw/wr_burst_ctrl.sv ====
/*
 * write burst sequencer of the DDR write path
 * aligned data/mask/enable pipeline, preamble detection,
 * output enable words and DQS strobe words for the DDIO blocks
 */

module wr_burst_ctrl (
	input  logic                                   clk,
	input  logic                                   dr_reset_n,
	// controller side, one beat pair per cycle while wr_en is high
	input  logic                                   wr_en,
	input  logic [phy_data_pkg::WDATA_WIDTH-1:0]   wdata,
	input  logic [phy_data_pkg::WDM_WIDTH-1:0]     wdm,
	// two-item words towards the DDIO blocks
	output logic [phy_data_pkg::WDATA_WIDTH-1:0]   dq_word,
	output logic [phy_data_pkg::WDM_WIDTH-1:0]     dm_word,
	output logic [phy_data_pkg::BEATS_PER_CYCLE-1:0] dqs_word,
	output logic [phy_data_pkg::BEATS_PER_CYCLE-1:0] dqs_n_word,
	output logic [phy_data_pkg::BEATS_PER_CYCLE-1:0] dq_oe_word,
	output logic [phy_data_pkg::BEATS_PER_CYCLE-1:0] dqs_oe_word
);

	// ************************************************************************
	// delay pipeline
	// ************************************************************************

	// stage 0 holds the pair sampled at the last edge
	logic                                 en_pipe   [phy_ctrl_pkg::WR_PIPE_DEPTH];
	logic [phy_data_pkg::WDATA_WIDTH-1:0] data_pipe [phy_ctrl_pkg::WR_PIPE_DEPTH];
	logic [phy_data_pkg::WDM_WIDTH-1:0]   mask_pipe [phy_ctrl_pkg::WR_PIPE_DEPTH];

	// cycle classification
	logic data_cycle;
	logic preamble_cycle;
	logic strobe_on;

	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			for (int i = 0; i < phy_ctrl_pkg::WR_PIPE_DEPTH; i++) begin
				en_pipe[i]   <= 1'b0;
				data_pipe[i] <= '0;
				mask_pipe[i] <= '0;
			end
		end else begin
			en_pipe[0]   <= wr_en;
			data_pipe[0] <= wdata;
			mask_pipe[0] <= wdm;
			// enable travels with its data so gaps line up exactly
			for (int i = 1; i < phy_ctrl_pkg::WR_PIPE_DEPTH; i++) begin
				en_pipe[i]   <= en_pipe[i-1];
				data_pipe[i] <= data_pipe[i-1];
				mask_pipe[i] <= mask_pipe[i-1];
			end
		end
	end

	// ************************************************************************
	// cycle classification
	// ************************************************************************

	// last stage high: this cycle carries a beat pair
	assign data_cycle = en_pipe[phy_ctrl_pkg::WR_PIPE_DEPTH-1];

	// rising edge of the enable one stage early
	// gives exactly one strobe cycle ahead of each burst,
	// back-to-back pairs never see it
	assign preamble_cycle = en_pipe[phy_ctrl_pkg::WR_PIPE_DEPTH-2]
		& ~en_pipe[phy_ctrl_pkg::WR_PIPE_DEPTH-1];

	// strobe pins driven in preamble and data cycles, no postamble
	assign strobe_on = data_cycle | preamble_cycle;

	// ************************************************************************
	// words towards the DDIO blocks
	// ************************************************************************

	// blank data and mask when idle so the pins stay quiet
	assign dq_word = data_cycle ? data_pipe[phy_ctrl_pkg::WR_PIPE_DEPTH-1] : '0;
	assign dm_word = data_cycle ? mask_pipe[phy_ctrl_pkg::WR_PIPE_DEPTH-1] : '0;

	// toggling strobe only with data, low in preamble and idle
	assign dqs_word = data_cycle ? phy_ctrl_pkg::DQS_DATA_PATTERN
		: phy_ctrl_pkg::DQS_PREAMBLE_PATTERN;

	// differential partner
	assign dqs_n_word = ~dqs_word;

	// enables cover both phases of the cycle
	assign dq_oe_word  = {phy_data_pkg::BEATS_PER_CYCLE{data_cycle}};
	assign dqs_oe_word = {phy_data_pkg::BEATS_PER_CYCLE{strobe_on}};

endmodule

// ==== hw/wr_path_top.sv ====
/*
 * top level of the DDR PHY write output path
 * burst sequencer feeding one soft DDIO block per pin group
 */

module wr_path_top (
	input  logic                                 clk,
	input  logic                                 dr_reset_n,
	// memory controller side
	input  logic                                 wr_en,
	input  logic [phy_data_pkg::WDATA_WIDTH-1:0] wdata,
	input  logic [phy_data_pkg::WDM_WIDTH-1:0]   wdm,
	// DDR pin side, two beats per clk cycle
	output logic [phy_data_pkg::DQ_WIDTH-1:0]    dq,
	output logic [phy_data_pkg::DM_WIDTH-1:0]    dm,
	output logic                                 dqs,
	output logic                                 dqs_n,
	output logic                                 dq_oe,
	output logic                                 dqs_oe
);

	// two-item words from the sequencer
	logic [phy_data_pkg::WDATA_WIDTH-1:0]     dq_word;
	logic [phy_data_pkg::WDM_WIDTH-1:0]       dm_word;
	logic [phy_data_pkg::BEATS_PER_CYCLE-1:0] dqs_word;
	logic [phy_data_pkg::BEATS_PER_CYCLE-1:0] dqs_n_word;
	logic [phy_data_pkg::BEATS_PER_CYCLE-1:0] dq_oe_word;
	logic [phy_data_pkg::BEATS_PER_CYCLE-1:0] dqs_oe_word;

	// ************************************************************************
	// sequencer
	// ************************************************************************

	wr_burst_ctrl u_burst_ctrl (
		.clk         (clk),
		.dr_reset_n  (dr_reset_n),
		.wr_en       (wr_en),
		.wdata       (wdata),
		.wdm         (wdm),
		.dq_word     (dq_word),
		.dm_word     (dm_word),
		.dqs_word    (dqs_word),
		.dqs_n_word  (dqs_n_word),
		.dq_oe_word  (dq_oe_word),
		.dqs_oe_word (dqs_oe_word)
	);

	// ************************************************************************
	// rate doubling, one block per pin group
	// ************************************************************************

	// data and mask
	ddio_out_soft #(.ITEM_WIDTH(phy_data_pkg::DQ_WIDTH)) u_ddio_dq (
		.clk(clk), .dr_reset_n(dr_reset_n), .datain(dq_word), .dataout(dq)
	);
	ddio_out_soft #(.ITEM_WIDTH(phy_data_pkg::DM_WIDTH)) u_ddio_dm (
		.clk(clk), .dr_reset_n(dr_reset_n), .datain(dm_word), .dataout(dm)
	);

	// strobe pair, dqs_n comes out of reset high
	ddio_out_soft #(.ITEM_WIDTH(1)) u_ddio_dqs (
		.clk(clk), .dr_reset_n(dr_reset_n), .datain(dqs_word), .dataout(dqs)
	);
	ddio_out_soft #(
		.ITEM_WIDTH          (1),
		.REG_POST_RESET_HIGH (phy_ctrl_pkg::DQS_N_RESET_HIGH)
	) u_ddio_dqs_n (
		.clk(clk), .dr_reset_n(dr_reset_n), .datain(dqs_n_word), .dataout(dqs_n)
	);

	// output enables, same delay as the pins they control
	ddio_out_soft #(.ITEM_WIDTH(1)) u_ddio_dq_oe (
		.clk(clk), .dr_reset_n(dr_reset_n), .datain(dq_oe_word), .dataout(dq_oe)
	);
	ddio_out_soft #(.ITEM_WIDTH(1)) u_ddio_dqs_oe (
		.clk(clk), .dr_reset_n(dr_reset_n), .datain(dqs_oe_word), .dataout(dqs_oe)
	);

endmodule

// ==== tests/wr_path_model.svh ====
/*
 * reference model of the DDR write path for the testbench
 * sample history queue, per-phase pin prediction and checker tasks
 */

`ifndef WR_PATH_MODEL_SVH
`define WR_PATH_MODEL_SVH

	// ************************************************************************
	// model state
	// ************************************************************************

	int unsigned err_count;
	int unsigned check_count;
	int unsigned bursts_started;
	int unsigned preambles_seen;
	int unsigned reset_age;

	// words seen by the DUT at each rising edge, oldest at index 0
	logic                                 hist_en   [$];
	logic [phy_data_pkg::WDATA_WIDTH-1:0] hist_data [$];
	logic [phy_data_pkg::WDM_WIDTH-1:0]   hist_mask [$];

	// expected pins, index 0 is the high phase, index 1 the low phase
	logic [phy_data_pkg::DQ_WIDTH-1:0] exp_dq     [2];
	logic [phy_data_pkg::DM_WIDTH-1:0] exp_dm     [2];
	logic                              exp_dqs    [2];
	logic                              exp_dqs_n  [2];
	logic                              exp_dq_oe  [2];
	logic                              exp_dqs_oe [2];
	string                             exp_kind;

	// history starts out as an idle pipeline
	task automatic clear_history();
		hist_en.delete();
		hist_data.delete();
		hist_mask.delete();
		for (int i = 0; i < 3; i++) begin
			hist_en.push_back(1'b0);
			hist_data.push_back('0);
			hist_mask.push_back('0);
		end
	endtask

	// record one edge and predict the pins for the cycle that follows it
	task automatic push_sample(input logic rst_n, input logic en,
		input logic [phy_data_pkg::WDATA_WIDTH-1:0] data,
		input logic [phy_data_pkg::WDM_WIDTH-1:0] mask);
		logic en_now;
		logic data_cyc;
		logic pre_cyc;
		// pipeline is held clear while reset is low
		en_now = rst_n & en;
		if (!rst_n) begin
			reset_age = 0;
		end else if (reset_age < 100) begin
			reset_age++;
		end
		if (en_now && !hist_en[2]) begin
			bursts_started++;
		end
		hist_en.push_back(en_now);
		hist_data.push_back(rst_n ? data : '0);
		hist_mask.push_back(rst_n ? mask : '0);
		void'(hist_en.pop_front());
		void'(hist_data.pop_front());
		void'(hist_mask.pop_front());
		// pins now show the pair taken two edges back
		data_cyc = hist_en[0];
		// first pair of a burst is one edge back, one strobe cycle ahead of it
		pre_cyc = hist_en[1] & ~hist_en[0];
		for (int ph = 0; ph < 2; ph++) begin
			exp_dq[ph] = data_cyc ? hist_data[0][ph*phy_data_pkg::DQ_WIDTH +: phy_data_pkg::DQ_WIDTH]
				: '0;
			exp_dm[ph] = data_cyc ? hist_mask[0][ph*phy_data_pkg::DM_WIDTH +: phy_data_pkg::DM_WIDTH]
				: '0;
			// strobe toggles only with data, high in the high phase
			exp_dqs[ph]    = data_cyc & (ph == 0);
			exp_dqs_n[ph]  = ~exp_dqs[ph];
			exp_dq_oe[ph]  = data_cyc;
			exp_dqs_oe[ph] = data_cyc | pre_cyc;
		end
		if (reset_age < 2) begin
			exp_kind = "reset";
		end else if (data_cyc) begin
			exp_kind = "data";
		end else if (pre_cyc) begin
			exp_kind = "preamble";
		end else begin
			exp_kind = "idle";
		end
	endtask

	// ************************************************************************
	// checks
	// ************************************************************************

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			err_count++;
			$display("Fail %s: expected 0x%0h, actual 0x%0h at %0t", name, expected,
				actual, $time);
		end
	endtask

	// compare all pins against the prediction for one clk phase
	task automatic check_phase(input int ph);
		string tag;
		tag = (ph == 0) ? "high" : "low";
		check_value($sformatf("%s dq %s", exp_kind, tag), exp_dq[ph], dq);
		check_value($sformatf("%s dm %s", exp_kind, tag), exp_dm[ph], dm);
		check_value($sformatf("%s dqs %s", exp_kind, tag), exp_dqs[ph], dqs);
		check_value($sformatf("%s dqs_n %s", exp_kind, tag), exp_dqs_n[ph], dqs_n);
		check_value($sformatf("%s dq_oe %s", exp_kind, tag), exp_dq_oe[ph], dq_oe);
		check_value($sformatf("%s dqs_oe %s", exp_kind, tag), exp_dqs_oe[ph], dqs_oe);
		// strobe driven low with data pins off marks a preamble on the pins
		if (ph == 0 && dqs_oe === 1'b1 && dq_oe === 1'b0 && dqs === 1'b0) begin
			preambles_seen++;
		end
	endtask

`endif

// ==== tests/wr_path_tb.sv ====
/*
 * testbench of the DDR write output path
 * clock, reset, random write bursts, watchdog and result report
 */

module wr_path_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 5;
	localparam int TEST_CYCLES  = 2000;
	localparam int DRAIN_CYCLES = 5;
	localparam int SEED         = 83663;
	localparam int CLK_HALF     = 5;
	// whole run plus a little slack, in ns
	localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + 10) * 2 * CLK_HALF;

	logic                                 clk;
	logic                                 dr_reset_n;
	logic                                 wr_en;
	logic [phy_data_pkg::WDATA_WIDTH-1:0] wdata;
	logic [phy_data_pkg::WDM_WIDTH-1:0]   wdm;
	logic [phy_data_pkg::DQ_WIDTH-1:0]    dq;
	logic [phy_data_pkg::DM_WIDTH-1:0]    dm;
	logic                                 dqs;
	logic                                 dqs_n;
	logic                                 dq_oe;
	logic                                 dqs_oe;

	// current wr_en run
	logic run_en;
	int   run_left;

	`include "wr_path_model.svh"

	wr_path_top u_dut (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.wr_en      (wr_en),
		.wdata      (wdata),
		.wdm        (wdm),
		.dq         (dq),
		.dm         (dm),
		.dqs        (dqs),
		.dqs_n      (dqs_n),
		.dq_oe      (dq_oe),
		.dqs_oe     (dqs_oe)
	);

	always #(CLK_HALF) clk = ~clk;

	// ************************************************************************
	// stimulus
	// ************************************************************************

	// wr_en in runs, on about two cycles out of three
	task automatic drive_next_pair();
		logic [31:0] rnd;
		if (run_left == 0) begin
			run_en   = ($urandom % 3) != 0;
			run_left = 1 + ($urandom % 8);
		end
		run_left--;
		rnd = $urandom;
		wr_en <= run_en;
		wdata <= $urandom;
		wdm   <= rnd[phy_data_pkg::WDM_WIDTH-1:0];
	endtask

	initial begin
		void'($urandom(SEED));
		clk        = 1'b0;
		dr_reset_n = 1'b0;
		wr_en      = 1'b0;
		wdata      = '0;
		wdm        = '0;
		run_en     = 1'b0;
		run_left   = 0;
		clear_history();
		repeat (RESET_CYCLES) @(posedge clk);
		dr_reset_n <= 1'b1;
		repeat (TEST_CYCLES) begin
			@(posedge clk);
			drive_next_pair();
		end
		// let the last burst leave the pins
		repeat (DRAIN_CYCLES) begin
			@(posedge clk);
			wr_en <= 1'b0;
		end
		@(negedge clk);
		#3;
		check_value("preamble count", bursts_started, preambles_seen);
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// ************************************************************************
	// model and phase sampling
	// ************************************************************************

	// values read here are the ones the DUT takes at this edge
	always @(posedge clk) begin
		push_sample(dr_reset_n, wr_en, wdata, wdm);
	end

	// middle of the high phase
	always @(posedge clk) begin
		#2.5;
		check_phase(0);
	end

	// middle of the low phase
	always @(negedge clk) begin
		#2.5;
		check_phase(1);
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

endmodule

// ==== wr_path_top.f ====
+incdir+tests
hw/phy_data_pkg.sv
hw/phy_ctrl_pkg.sv
hw/ddio_out_soft.sv
hw/wr_burst_ctrl.sv
hw/wr_path_top.sv
tests/wr_path_tb.sv
